// ==== rtl/usb_proto_pkg.sv ====
// ----------------------------------------------------------
// full-speed USB line protocol constants for the IN transmit path
// import into any block that frames packets or drives the line
// ----------------------------------------------------------
package usb_proto_pkg;

    // 60 MHz clock, 12 Mbit/s line
    localparam int unsigned BIT_CYCLES = 5;      // clocks per line bit

    localparam logic [7:0]  SYNC_BYTE  = 8'h80;  // KJKJKJKK, sent lsb first
    localparam int unsigned STUFF_RUN  = 6;      // ones before a stuffed zero

    // CRC16 x^16+x^15+x^2+1, bit-reversed for lsb-first shifting
    localparam logic [15:0] CRC16_POLY = 16'hA001;
    localparam logic [15:0] CRC16_INIT = 16'hFFFF; // sent inverted, low byte first

    // data PIDs, the byte on the wire is {~pid, pid}
    typedef enum logic [3:0] {
        PID_DATA0 = 4'h3,
        PID_DATA1 = 4'hB
    } pid_t;

endpackage

// ==== rtl/usb_ep_pkg.sv ====
// ----------------------------------------------------------
// IN endpoint sizing shared by the buffers, the arbiter and the
// packet framer
// ----------------------------------------------------------
package usb_ep_pkg;

    localparam int unsigned NUM_EP  = 4;   // IN endpoints
    localparam int unsigned MAX_PKT = 8;   // largest payload in bytes

    typedef logic [$clog2(NUM_EP)-1:0]  ep_idx_t;    // endpoint number
    typedef logic [$clog2(MAX_PKT):0]   pkt_len_t;   // 0 .. MAX_PKT bytes
    typedef logic [$clog2(MAX_PKT)-1:0] byte_idx_t;  // read position

endpackage

// ==== rtl/in_ep_buffer.sv ====
// ----------------------------------------------------------
// single-packet IN endpoint buffer
// collects bytes over valid/ready, closes on last or when full,
// then holds the packet pending until the transmitter releases it
// ----------------------------------------------------------
`timescale 1ns/1ps

module in_ep_buffer
    import usb_ep_pkg::*;
    import usb_proto_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic [7:0] data,
    input  logic      valid,
    input  logic      last,
    input  logic      pkt_release,  // packet is on the wire, free the buffer
    input  byte_idx_t rd_idx,
    output logic      ready,
    output logic      pending,
    output pkt_len_t  len,
    output pid_t      pid,
    output logic [7:0] rd_byte
);

    logic [7:0] mem [MAX_PKT];  // payload store
    pkt_len_t   wr_cnt;         // bytes taken so far
    logic       toggle;         // 0: DATA0 next, 1: DATA1 next
    logic       accept;
    logic       close;

    assign ready  = ~pending;               // back-pressure while full
    assign accept = valid & ready;
    assign close  = accept & (last | (wr_cnt == pkt_len_t'(MAX_PKT - 1)));

    // ----------------------------------------------------------
    // fill and release
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_cnt  <= '0;
            pending <= 1'b0;
            toggle  <= 1'b0;   // DATA0 first after reset
        end else if (pkt_release) begin
            wr_cnt  <= '0;
            pending <= 1'b0;
            toggle  <= ~toggle;
        end else if (accept) begin
            wr_cnt  <= wr_cnt + 1'b1;
            pending <= close;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            mem[byte_idx_t'(wr_cnt)] <= data;
    end

    assign len     = wr_cnt;                          // valid once pending
    assign pid     = toggle ? PID_DATA1 : PID_DATA0;
    assign rd_byte = mem[rd_idx];

    // a release only ever arrives for a packet that is pending
    a_release_pending : assert property (@(posedge clk) disable iff (!rstn)
        pkt_release |-> pending);

endmodule

// ==== rtl/tx_arbiter.sv ====
// ----------------------------------------------------------
// round-robin owner of the shared buffer read bus
// grants one pending endpoint at a time, holds the grant until
// the packet is done, then releases that endpoint's buffer
// ----------------------------------------------------------
`timescale 1ns/1ps

module tx_arbiter
    import usb_ep_pkg::*;
    import usb_proto_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [NUM_EP-1:0]            pending,
    input  pkt_len_t [NUM_EP-1:0]        len,
    input  pid_t [NUM_EP-1:0]            pid,
    input  logic [NUM_EP-1:0][7:0]       rd_byte_ep,
    input  byte_idx_t                    rd_idx_in,
    input  logic                         pkt_done,
    output logic                         grant_valid,
    output pkt_len_t                     grant_len,
    output pid_t                         grant_pid,
    output logic [7:0]                   rd_byte,
    output byte_idx_t                    rd_idx,
    output logic [NUM_EP-1:0]            pkt_release
);

    ep_idx_t grant_ep;   // endpoint that owns the bus
    ep_idx_t last_ep;    // last one served, search starts after it
    ep_idx_t next_ep;
    logic    next_found;

    // first pending endpoint after the last one served
    always_comb begin
        next_found = 1'b0;
        next_ep    = last_ep;
        for (int i = 1; i <= NUM_EP; i++) begin
            if (!next_found && pending[ep_idx_t'(last_ep + i)]) begin
                next_found = 1'b1;
                next_ep    = ep_idx_t'(last_ep + i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            grant_valid <= 1'b0;
            grant_ep    <= '0;
            last_ep     <= ep_idx_t'(NUM_EP - 1);  // endpoint 0 goes first
        end else if (grant_valid) begin
            if (pkt_done)
                grant_valid <= 1'b0;
        end else if (next_found) begin
            grant_valid <= 1'b1;
            grant_ep    <= next_ep;
            last_ep     <= next_ep;
        end
    end

    // shared bus mux
    assign grant_len   = len[grant_ep];
    assign grant_pid   = pid[grant_ep];
    assign rd_byte     = rd_byte_ep[grant_ep];
    assign rd_idx      = rd_idx_in;           // same read position to all buffers
    assign pkt_release = (grant_valid && pkt_done) ? NUM_EP'(1) << grant_ep : '0;

    // the granted buffer stays pending until its release
    a_grant_pending : assert property (@(posedge clk) disable iff (!rstn)
        grant_valid |-> pending[grant_ep]);

endmodule

// ==== rtl/packet_tx.sv ====
// ----------------------------------------------------------
// packet framer for the granted endpoint
// hands SYNC, PID, payload and CRC16 bytes to the bit transmitter
// one byte per byte_req, then waits for the EOP
// ----------------------------------------------------------
`timescale 1ns/1ps

module packet_tx
    import usb_ep_pkg::*;
    import usb_proto_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       grant_valid,
    input  pkt_len_t   grant_len,
    input  pid_t       grant_pid,
    input  logic [7:0] rd_byte,
    input  logic       byte_req,
    input  logic       tx_done,
    output byte_idx_t  rd_idx,
    output logic       tx_active,
    output logic [7:0] tx_byte,
    output logic       tx_last,
    output logic       pkt_done
);

    typedef enum logic [2:0] {
        IDLE,
        SYNC,
        PID,
        DATA,
        CRC_LO,
        CRC_HI,
        WAIT_EOP
    } state_t;

    state_t      state;
    logic [15:0] crc;
    logic        last_data;  // rd_idx points at the final payload byte

    // one byte through the reflected CRC16, lsb first
    function automatic logic [15:0] crc16_byte(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i])
                r = (r >> 1) ^ CRC16_POLY;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    assign last_data = ({1'b0, rd_idx} + 1'b1) == grant_len;

    // ----------------------------------------------------------
    // byte sequencer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= IDLE;
            crc    <= CRC16_INIT;
            rd_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_valid) begin
                        state  <= SYNC;
                        crc    <= CRC16_INIT;
                        rd_idx <= '0;
                    end
                end
                SYNC:   if (byte_req) state <= PID;
                PID:    if (byte_req) state <= DATA;  // a packet has at least one byte
                DATA: begin
                    if (byte_req) begin
                        crc <= crc16_byte(crc, rd_byte);  // same byte that goes out
                        if (last_data)
                            state <= CRC_LO;
                        else
                            rd_idx <= rd_idx + 1'b1;
                    end
                end
                CRC_LO: if (byte_req) state <= CRC_HI;
                CRC_HI: if (byte_req) state <= WAIT_EOP;
                WAIT_EOP: if (tx_done) state <= IDLE;  // grant drops on the same edge
                default: state <= IDLE;
            endcase
        end
    end

    // byte presented to the serializer
    always_comb begin
        case (state)
            SYNC:    tx_byte = SYNC_BYTE;
            PID:     tx_byte = {~grant_pid, grant_pid};
            DATA:    tx_byte = rd_byte;
            CRC_LO:  tx_byte = ~crc[7:0];
            CRC_HI:  tx_byte = ~crc[15:8];
            default: tx_byte = 8'h00;
        endcase
    end

    assign tx_active = (state != IDLE);
    assign tx_last   = (state == CRC_HI);
    assign pkt_done  = (state == WAIT_EOP) && tx_done;  // one clock, after the EOP

endmodule

// ==== rtl/bit_tx.sv ====
// ----------------------------------------------------------
// bit-level transmitter
// serializes bytes lsb first with bit stuffing and NRZI coding,
// drives D+/D- for BIT_CYCLES clocks per bit, ends with SE0 SE0 J
// ----------------------------------------------------------
`timescale 1ns/1ps

module bit_tx
    import usb_proto_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       tx_active,
    input  logic [7:0] tx_byte,
    input  logic       tx_last,
    output logic       byte_req,
    output logic       tx_done,
    output logic       usb_dp,
    output logic       usb_dn,
    output logic       usb_oe
);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        SE0,
        IDLE_J
    } state_t;

    state_t     state;
    logic [2:0] cyc;        // clock within the bit time
    logic [7:0] sh;         // bits still to send, lsb next
    logic [2:0] nbits;      // bits left in sh, SE0 bit count in SE0
    logic [2:0] ones;       // run of ones since the last transition
    logic       line;       // NRZI level, 1 = J
    logic       last_byte;  // sh holds the final byte
    logic       bit_end;
    logic       slot_start;
    logic       stuff;
    logic       send_bit;
    logic       cur_bit;

    assign bit_end    = (cyc == 3'(BIT_CYCLES - 1));
    assign slot_start = (state == IDLE && tx_active) || (state == SHIFT && bit_end);
    assign stuff      = (ones == 3'(STUFF_RUN));  // next slot is a stuffed zero
    assign byte_req   = slot_start && !stuff && nbits == '0 && (state == IDLE || !last_byte);
    assign send_bit   = slot_start && !stuff && (byte_req || nbits != '0);
    assign cur_bit    = byte_req ? tx_byte[0] : sh[0];

    // ----------------------------------------------------------
    // line sequencer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            cyc       <= '0;
            sh        <= '0;
            nbits     <= '0;
            ones      <= '0;
            line      <= 1'b1;
            last_byte <= 1'b0;
        end else begin
            if (state != IDLE)
                cyc <= bit_end ? '0 : cyc + 1'b1;
            case (state)
                IDLE:  if (tx_active) state <= SHIFT;  // first sync bit goes out now
                SHIFT: begin
                    if (bit_end && !stuff && nbits == '0 && last_byte) begin
                        state <= SE0;
                        nbits <= 3'd1;                 // two SE0 bit times
                    end
                end
                SE0: begin
                    if (bit_end) begin
                        if (nbits == '0) begin
                            state <= IDLE_J;
                            line  <= 1'b1;
                        end else begin
                            nbits <= nbits - 1'b1;
                        end
                    end
                end
                IDLE_J: begin
                    if (bit_end) begin
                        state <= IDLE;
                        ones  <= '0;
                    end
                end
                default: state <= IDLE;
            endcase

            // NRZI: zero toggles, one holds
            if (slot_start && stuff) begin
                line <= ~line;
                ones <= '0;
            end else if (send_bit) begin
                if (cur_bit) begin
                    ones <= ones + 1'b1;
                end else begin
                    line <= ~line;
                    ones <= '0;
                end
            end

            if (byte_req) begin
                sh        <= {1'b0, tx_byte[7:1]};  // bit 0 already on the line
                nbits     <= 3'd7;
                last_byte <= tx_last;
            end else if (send_bit) begin
                sh    <= sh >> 1;
                nbits <= nbits - 1'b1;
            end
        end
    end

    assign tx_done = (state == IDLE_J) && bit_end;
    assign usb_oe  = (state != IDLE);
    assign usb_dp  = (state == SE0) ? 1'b0 : line;
    assign usb_dn  = (state == SE0) ? 1'b0 : ~line;

    // the driver lets go in the same clock the framer ends the packet
    a_oe_fall : assert property (@(posedge clk) disable iff (!rstn)
        $fell(usb_oe) == $fell(tx_active));

endmodule

// ==== rtl/usb_in_tx_top.sv ====
// ----------------------------------------------------------
// full-speed USB IN transmit path, four endpoints
// user logic feeds bytes per endpoint, the line comes out as
// D+/D- with a separate output enable for the pad
// ----------------------------------------------------------
`timescale 1ns/1ps

module usb_in_tx_top
    import usb_ep_pkg::*;
    import usb_proto_pkg::*;
(
    input  logic                   clk,     // 60 MHz
    input  logic                   rstn,
    input  logic [NUM_EP-1:0][7:0] ep_data,
    input  logic [NUM_EP-1:0]      ep_valid,
    output logic [NUM_EP-1:0]      ep_ready,
    input  logic [NUM_EP-1:0]      ep_last,
    output logic                   usb_dp,
    output logic                   usb_dn,
    output logic                   usb_oe
);

    // ----------------------------------------------------------
    // buffers to arbiter
    // ----------------------------------------------------------
    logic [NUM_EP-1:0]      ep_pending;
    pkt_len_t [NUM_EP-1:0]  ep_len;
    pid_t [NUM_EP-1:0]      ep_pid;
    logic [NUM_EP-1:0][7:0] ep_rd_byte;
    logic [NUM_EP-1:0]      ep_release;
    byte_idx_t              rd_idx;      // fanned out to every buffer
    byte_idx_t              pt_rd_idx;   // from the framer

    // arbiter to framer to serializer
    logic       grant_valid;
    pkt_len_t   grant_len;
    pid_t       grant_pid;
    logic [7:0] rd_byte;
    logic       pkt_done;
    logic       tx_active;
    logic [7:0] tx_byte;
    logic       tx_last;
    logic       byte_req;
    logic       tx_done;

    for (genvar e = 0; e < NUM_EP; e++) begin : g_ep
        in_ep_buffer u_buf (
            .clk         ( clk            ),
            .rstn        ( rstn           ),
            .data        ( ep_data[e]     ),
            .valid       ( ep_valid[e]    ),
            .last        ( ep_last[e]     ),
            .pkt_release ( ep_release[e]  ),
            .rd_idx      ( rd_idx         ),
            .ready       ( ep_ready[e]    ),
            .pending     ( ep_pending[e]  ),
            .len         ( ep_len[e]      ),
            .pid         ( ep_pid[e]      ),
            .rd_byte     ( ep_rd_byte[e]  )
        );
    end

    tx_arbiter u_arb (
        .clk         ( clk         ),
        .rstn        ( rstn        ),
        .pending     ( ep_pending  ),
        .len         ( ep_len      ),
        .pid         ( ep_pid      ),
        .rd_byte_ep  ( ep_rd_byte  ),
        .rd_idx_in   ( pt_rd_idx   ),
        .pkt_done    ( pkt_done    ),
        .grant_valid ( grant_valid ),
        .grant_len   ( grant_len   ),
        .grant_pid   ( grant_pid   ),
        .rd_byte     ( rd_byte     ),
        .rd_idx      ( rd_idx      ),
        .pkt_release ( ep_release  )
    );

    packet_tx u_pkt (
        .clk         ( clk         ),
        .rstn        ( rstn        ),
        .grant_valid ( grant_valid ),
        .grant_len   ( grant_len   ),
        .grant_pid   ( grant_pid   ),
        .rd_byte     ( rd_byte     ),
        .byte_req    ( byte_req    ),
        .tx_done     ( tx_done     ),
        .rd_idx      ( pt_rd_idx   ),
        .tx_active   ( tx_active   ),
        .tx_byte     ( tx_byte     ),
        .tx_last     ( tx_last     ),
        .pkt_done    ( pkt_done    )
    );

    bit_tx u_bit (
        .clk         ( clk         ),
        .rstn        ( rstn        ),
        .tx_active   ( tx_active   ),
        .tx_byte     ( tx_byte     ),
        .tx_last     ( tx_last     ),
        .byte_req    ( byte_req    ),
        .tx_done     ( tx_done     ),
        .usb_dp      ( usb_dp      ),
        .usb_dn      ( usb_dn      ),
        .usb_oe      ( usb_oe      )
    );

endmodule

// ==== test/tb_usb_in_tx.sv ====
// ----------------------------------------------------------
// testbench for the four-endpoint USB IN transmit path
// random packets per endpoint from a fixed seed, then an all-0xFF
// phase for bit stuffing; a line decoder rebuilds each packet from
// D+/D- and checks it against per-endpoint expected queues
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_usb_in_tx
    import usb_ep_pkg::*;
    import usb_proto_pkg::*;
();

    localparam int     SEED        = 50696;
    localparam int     PKTS_PER_EP = 8;                 // packets per endpoint
    localparam int     FF_FROM     = 6;                 // later packets are all 0xFF
    localparam int     NUM_PKTS    = NUM_EP * PKTS_PER_EP;
    localparam int     WORST_BITS  = 120;               // sync..crc, stuffing and EOP
    localparam longint WATCHDOG_NS = longint'(NUM_PKTS) * WORST_BITS * BIT_CYCLES * 40 * 4;

    logic                   clk;
    logic                   rstn;
    logic [NUM_EP-1:0][7:0] ep_data;
    logic [NUM_EP-1:0]      ep_valid;
    logic [NUM_EP-1:0]      ep_ready;
    logic [NUM_EP-1:0]      ep_last;
    logic                   usb_dp;
    logic                   usb_dn;
    logic                   usb_oe;

    // reference model state, one entry per endpoint
    logic [63:0] exp_data [NUM_EP][$];   // expected payloads, byte 0 in bits 7:0
    int          exp_len  [NUM_EP][$];
    pid_t        exp_pid  [NUM_EP][$];   // predicted data toggle
    logic [63:0] cur_data [NUM_EP] = '{default: '0};  // packet being collected
    int          cur_len  [NUM_EP] = '{default: 0};
    logic        tog      [NUM_EP] = '{default: 1'b0};
    logic        take     [NUM_EP] = '{default: 1'b0}; // byte taken at the coming edge
    int          closed_cnt [NUM_EP] = '{default: 0};
    int          seen_cnt   [NUM_EP] = '{default: 0};

    // driver state
    int left [NUM_EP] = '{default: 0};   // bytes still to offer
    int plen [NUM_EP] = '{default: 0};
    int gap  [NUM_EP] = '{default: 0};   // idle cycles before the next byte
    int sent [NUM_EP] = '{default: 0};   // packets started

    logic [7:0] rx_q [$];                // decoded bytes of the current packet
    int         rx_bits;
    int         decoded_cnt  = 0;
    int         mismatch_cnt = 0;
    int         error_cnt    = 0;

    usb_in_tx_top UUT (
        .clk      ( clk      ),
        .rstn     ( rstn     ),
        .ep_data  ( ep_data  ),
        .ep_valid ( ep_valid ),
        .ep_ready ( ep_ready ),
        .ep_last  ( ep_last  ),
        .usb_dp   ( usb_dp   ),
        .usb_dn   ( usb_dn   ),
        .usb_oe   ( usb_oe   )
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH %s: expected %0h actual %0h", name, exp, act);
        mismatch_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        error_cnt++;
    endtask

    // data CRC16 over n payload bytes, lsb of each byte first, sent inverted
    function automatic logic [15:0] payload_crc(input logic [63:0] d, input int n);
        logic [15:0] c;
        logic        fb;
        c = CRC16_INIT;
        for (int k = 0; k < 8 * n; k++) begin
            fb = c[0] ^ d[k];
            c  = c >> 1;
            if (fb)
                c = c ^ CRC16_POLY;
        end
        return ~c;
    endfunction

    // ----------------------------------------------------------
    // stimulus, one step per rising edge for every endpoint
    // ----------------------------------------------------------
    task automatic drive_step();
        for (int e = 0; e < NUM_EP; e++) begin
            if (ep_valid[e] && take[e]) begin
                left[e]--;
                if (left[e] == 0)
                    gap[e] = $urandom_range(0, 6);             // between packets
                else if ($urandom_range(0, 3) == 0)
                    gap[e] = $urandom_range(1, 3);             // hole inside a packet
            end
            if (!ep_valid[e] || take[e]) begin                 // else hold the byte
                if (gap[e] > 0) begin
                    ep_valid[e] <= 1'b0;
                    gap[e]--;
                end else begin
                    if (left[e] == 0 && sent[e] < PKTS_PER_EP) begin
                        if (sent[e] >= FF_FROM)
                            plen[e] = int'(MAX_PKT) - e;       // 0xFF packets differ per ep
                        else
                            plen[e] = $urandom_range(1, MAX_PKT);
                        left[e] = plen[e];
                        sent[e]++;
                    end
                    if (left[e] > 0) begin
                        ep_valid[e] <= 1'b1;
                        ep_data[e]  <= (sent[e] > FF_FROM) ? 8'hFF : 8'($urandom);
                        ep_last[e]  <= (left[e] == 1) && (plen[e] < int'(MAX_PKT));
                    end else begin
                        ep_valid[e] <= 1'b0;
                        ep_last[e]  <= 1'b0;
                    end
                end
            end
        end
    endtask

    // ----------------------------------------------------------
    // input monitor, builds the expected queues
    // ----------------------------------------------------------
    always @(negedge clk) begin
        for (int e = 0; e < NUM_EP; e++) begin
            take[e] = rstn && ep_valid[e] && ep_ready[e];
            // a closed packet not yet on the line must hold ready low
            if (closed_cnt[e] > seen_cnt[e] && ep_ready[e])
                report_error($sformatf("ep%0d ready high while its packet is pending", e));
            if (take[e]) begin
                cur_data[e] = cur_data[e] | (64'(ep_data[e]) << (8 * cur_len[e]));
                cur_len[e]++;
                if (ep_last[e] || cur_len[e] == int'(MAX_PKT)) begin
                    exp_data[e].push_back(cur_data[e]);
                    exp_len[e].push_back(cur_len[e]);
                    exp_pid[e].push_back(tog[e] ? PID_DATA1 : PID_DATA0);
                    tog[e]        = ~tog[e];
                    closed_cnt[e] = closed_cnt[e] + 1;
                    cur_data[e]   = '0;
                    cur_len[e]    = 0;
                end
            end
        end
    end

    task automatic check_packet();
        int          nb;
        int          n;
        int          hit;
        int          nhit;
        logic [63:0] data;
        logic [15:0] crc_rx;
        logic [3:0]  pid;
        nb = rx_q.size();
        if (rx_bits % 8 != 0 || nb < 5 || nb > int'(MAX_PKT) + 4) begin
            report_error($sformatf("packet of %0d bits is not a whole data packet", rx_bits));
            decoded_cnt++;
            return;
        end
        if (rx_q[0] != SYNC_BYTE)
            report_mismatch("sync", 64'(SYNC_BYTE), 64'(rx_q[0]));
        pid = rx_q[1][3:0];
        if (rx_q[1][7:4] != ~pid)
            report_mismatch("pid_check", 64'({~pid, pid}), 64'(rx_q[1]));
        n    = nb - 4;                                   // payload bytes
        data = '0;
        for (int i = 0; i < n; i++)
            data = data | (64'(rx_q[2 + i]) << (8 * i));
        crc_rx = {rx_q[nb - 1], rx_q[nb - 2]};           // low byte first on the wire
        if (crc_rx != payload_crc(data, n))
            report_mismatch("crc16", 64'(payload_crc(data, n)), 64'(crc_rx));
        hit  = -1;
        nhit = 0;
        for (int e = 0; e < NUM_EP; e++) begin
            if (exp_data[e].size() > 0 && exp_len[e][0] == n && exp_data[e][0] == data) begin
                if (hit < 0)
                    hit = e;
                nhit++;
            end
        end
        if (nhit == 0)
            report_error($sformatf("%0d-byte packet %0h matches no endpoint queue", n, data));
        else if (nhit > 1)
            report_error($sformatf("%0d-byte packet %0h matches the heads of %0d queues",
                                   n, data, nhit));
        if (hit >= 0) begin
            if (pid != exp_pid[hit][0])
                report_mismatch($sformatf("toggle_ep%0d", hit), 64'(exp_pid[hit][0]), 64'(pid));
            void'(exp_data[hit].pop_front());
            void'(exp_len[hit].pop_front());
            void'(exp_pid[hit].pop_front());
            seen_cnt[hit] = seen_cnt[hit] + 1;
        end
        decoded_cnt++;
    endtask

    // rest of the EOP after the first SE0 sample, mid-bit samples
    task automatic check_eop();
        repeat (BIT_CYCLES) @(negedge clk);
        if (usb_dp || usb_dn)
            report_error("second SE0 bit time missing");
        repeat (BIT_CYCLES) @(negedge clk);
        if (!usb_dp || usb_dn || !usb_oe)
            report_error("idle J bit after SE0 missing");
        repeat (2) @(negedge clk);
        if (!usb_oe)
            report_error("usb_oe fell before the end of the J bit");
        @(negedge clk);
        if (usb_oe)
            report_error("usb_oe still high after the J bit");
    endtask

    // ----------------------------------------------------------
    // line decoder: NRZI, unstuffing, EOP
    // ----------------------------------------------------------
    initial begin : line_decoder
        logic       prev;
        logic       lvl;
        logic       b;
        logic [7:0] sh;
        int         ones;
        forever begin
            @(negedge clk);
            if (usb_oe) begin                            // first clock of the sync bit
                repeat (2) @(negedge clk);               // to mid-bit
                prev    = 1'b1;                          // line idles at J
                ones    = 0;
                sh      = '0;
                rx_bits = 0;
                rx_q.delete();
                while ((usb_dp || usb_dn) && rx_bits <= 8 * (int'(MAX_PKT) + 4)) begin
                    if (usb_dp && usb_dn)
                        report_error("both lines high during a packet");
                    lvl  = usb_dp;
                    b    = (lvl == prev);                // no transition is a one
                    prev = lvl;
                    if (ones == int'(STUFF_RUN)) begin
                        if (b)
                            report_error("stuffed zero missing after a run of six ones");
                        ones = 0;                        // drop the stuffed bit
                    end else begin
                        sh = {b, sh[7:1]};               // lsb first
                        rx_bits++;
                        if (rx_bits % 8 == 0)
                            rx_q.push_back(sh);
                        ones = b ? ones + 1 : 0;
                    end
                    repeat (BIT_CYCLES) @(negedge clk);
                end
                check_packet();
                check_eop();
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired with %0d of %0d packets decoded",
                 decoded_cnt, NUM_PKTS);
        $display("test failed");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rstn     = 1'b0;
        ep_data  = '0;
        ep_valid = '0;
        ep_last  = '0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (usb_oe)
            report_error("usb_oe high during reset");
        @(posedge clk);
        rstn <= 1'b1;                                    // after 5 cycles low
        while (decoded_cnt < NUM_PKTS) begin
            @(posedge clk);
            drive_step();
        end
        repeat (4 * BIT_CYCLES) @(posedge clk);          // let the last EOP finish
        for (int e = 0; e < NUM_EP; e++) begin
            if (exp_data[e].size() != 0)
                report_error($sformatf("ep%0d has %0d packets never sent",
                                       e, exp_data[e].size()));
        end
        $display("packets %0d of %0d, mismatches %0d, other errors %0d",
                 decoded_cnt, NUM_PKTS, mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/usb_proto_pkg.sv
rtl/usb_ep_pkg.sv
rtl/in_ep_buffer.sv
rtl/tx_arbiter.sv
rtl/packet_tx.sv
rtl/bit_tx.sv
rtl/usb_in_tx_top.sv
test/tb_usb_in_tx.sv

// ==== Makefile ====
# Verilator build and run of the USB IN transmit testbench
TOP := tb_usb_in_tx

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
